/* bench/bpu_checker.sv */
`timescale 1ns/100ps
`include "bpu_params.svh"

module bpu_checker
    import bpu_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  t_fetch_req fetch,
    input  t_train_pkt train,
    input  logic       dis_br_pred,
    input  t_pred      pred,
    input  logic       train_drop,
    output int         errors,
    output int         checks
);

    int         err_cnt = 0;
    int         chk_cnt = 0;
    logic       armed = 1'b0;
    logic [1:0] cntr;
    t_btb_row   tbl [`BPU_BTB_ROWS];
    t_btb_row   pend [$];          // model of the install queue
    t_btb_row   head_row;
    t_btb_row   new_row;
    t_btb_row   exp_row;
    t_paddr     exp_pc;
    logic       full_now;
    logic       exp_valid;
    logic       exp_br;
    logic       exp_drop;
    logic       exp_taken;

    assign errors = err_cnt;
    assign checks = chk_cnt;

    function automatic int row_of(input t_paddr pc);
        return int'((pc >> `BPU_BTB_IDX_LSB) % `BPU_BTB_ROWS);
    endfunction

    // conditional branch, jal, jalr
    function automatic logic is_branch_op(input logic [6:0] op);
        case (op)
            7'h63, 7'h6f, 7'h67: return 1'b1;
            default:             return 1'b0;
        endcase
    endfunction

    task automatic check_bit(input string what, input logic got, input logic want);
        chk_cnt++;
        if (got !== want) begin
            $display("[FAIL] %0t: %s got %b expected %b", $time, what, got, want);
            err_cnt++;
        end
    endtask

    task automatic check_word(input string what, input t_paddr got, input t_paddr want);
        chk_cnt++;
        if (got !== want) begin
            $display("[FAIL] %0t: %s got %h expected %h", $time, what, got, want);
            err_cnt++;
        end
    endtask

    // --------------------------------------------------
    // model update at each rising edge
    // --------------------------------------------------
    always @(posedge clk) begin
        if (reset) begin
            armed     = 1'b0;
            cntr      = 2'b01;
            exp_valid = 1'b0;
            exp_drop  = 1'b0;
            pend.delete();
            for (int i = 0; i < `BPU_BTB_ROWS; i++) begin
                tbl[i] = '0;
            end
        end else begin
            armed     = 1'b1;
            full_now  = (pend.size() == `BPU_TQ_DEPTH);    // before any pop
            exp_valid = fetch.valid;
            exp_drop  = 1'b0;
            if (fetch.valid) begin
                exp_row = tbl[row_of(fetch.pc)];
                exp_pc  = fetch.pc;
                exp_br  = is_branch_op(fetch.instr[6:0]);
            end else if (pend.size() != 0) begin
                head_row = pend.pop_front();    // free port lets the head land
                tbl[row_of(head_row.pc)] = head_row;
            end
            if (train.valid) begin
                if (train.taken) begin
                    if (cntr != 2'd3) cntr = cntr + 2'd1;
                    if (full_now) begin
                        exp_drop = 1'b1;
                    end else begin
                        new_row.valid  = 1'b1;
                        new_row.pc     = train.pc;
                        new_row.target = train.target;
                        pend.push_back(new_row);
                    end
                end else if (cntr != 2'd0) begin
                    cntr = cntr - 2'd1;
                end
            end
        end
    end

    // compare mid-cycle on settled outputs
    always @(negedge clk) begin
        if (armed && !reset) begin
            exp_taken = exp_valid & exp_row.valid & (exp_row.pc == exp_pc) & exp_br
                        & cntr[1] & ~dis_br_pred;
            check_bit("pred.valid", pred.valid, exp_valid);
            check_bit("pred.taken", pred.taken, exp_taken);
            if (exp_valid) check_word("pred.pc_nxt", pred.pc_nxt, exp_row.target);
            check_bit("train_drop", train_drop, exp_drop);
        end
    end

endmodule

/* bench/tb_bpu.sv */
`timescale 1ns/100ps

module tb_bpu
    import bpu_pkg::*;
();

    localparam int RESET_CYCLES = 10;
    localparam int LEN_COLD  = 12;
    localparam int LEN_HIT   = 9;
    localparam int LEN_SAT   = 20;
    localparam int LEN_FILT  = 12;
    localparam int LEN_DEFER = 30;
    localparam int LEN_RAND  = 400;
    localparam int MARGIN    = 50;
    localparam int BUDGET    = LEN_COLD + LEN_HIT + LEN_SAT + LEN_FILT + LEN_DEFER
                               + LEN_RAND + 2 + RESET_CYCLES + MARGIN;

    localparam logic [6:0] OP_BR = 7'h63;

    logic       clk = 1'b0;
    logic       reset;
    logic       dis_br_pred;
    logic       train_drop;
    t_fetch_req fetch;
    t_train_pkt train;
    t_pred      pred;
    int         errors;
    int         checks;
    int         err_base = 0;
    int         tests_run = 0;
    int         tests_failed = 0;
    integer     seed = 32'hac5dc095;
    logic [31:0] r;

    // rows 16 and 2 are shared by two pcs each
    t_paddr     pc_pool [8] = '{32'h1040, 32'h10c0, 32'h1044, 32'h2008,
                                32'h2088, 32'h300c, 32'h1050, 32'h207c};
    logic [6:0] op_list [6] = '{7'h63, 7'h6f, 7'h67, 7'h33, 7'h13, 7'h03};
    int         defer_idx [6] = '{3, 5, 6, 4, 7, 2};    // 4 aliases 3

    bpu_top DUT (.clk(clk), .reset(reset), .fetch(fetch), .train(train),
                 .dis_br_pred(dis_br_pred), .pred(pred), .train_drop(train_drop));

    bpu_checker chk (.clk(clk), .reset(reset), .fetch(fetch), .train(train),
                     .dis_br_pred(dis_br_pred), .pred(pred), .train_drop(train_drop),
                     .errors(errors), .checks(checks));

    always #50 clk = ~clk;

    // --------------------------------------------------
    // stimulus helpers with one call per cycle
    // --------------------------------------------------
    task automatic drive_cycle(input logic fv, input t_paddr fpc, input logic [6:0] fop,
                               input logic tv, input logic tt, input t_paddr tpc,
                               input t_paddr ttgt);
        fetch = '{valid: fv, pc: fpc, instr: {25'h0, fop}};
        train = '{valid: tv, taken: tt, pc: tpc, target: ttgt};
        @(posedge clk);
        #5;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) drive_cycle(1'b0, '0, 7'h0, 1'b0, 1'b0, '0, '0);
    endtask

    task automatic lookup(input t_paddr pc, input logic [6:0] op);
        drive_cycle(1'b1, pc, op, 1'b0, 1'b0, '0, '0);
    endtask

    task automatic train_branch(input logic taken, input t_paddr pc, input t_paddr tgt);
        drive_cycle(1'b0, '0, 7'h0, 1'b1, taken, pc, tgt);
    endtask

    task automatic close_test(input string name);
        int n;
        idle_cycles(2);    // let the last prediction be compared
        n = errors - err_base;
        err_base = errors;
        tests_run++;
        if (n != 0) tests_failed++;
        $display("test %-22s done, %0d mismatches", name, n);
    endtask

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------
    initial begin
        reset = 1'b1;
        dis_br_pred = 1'b0;
        fetch = '0;
        train = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #5 reset = 1'b0;

        for (int i = 0; i < 8; i++) lookup(pc_pool[i], op_list[i % 3]);
        close_test("cold after reset");

        train_branch(1'b1, pc_pool[0], 32'h2000);
        train_branch(1'b1, pc_pool[0], 32'h2000);
        idle_cycles(3);
        lookup(pc_pool[0], OP_BR);
        lookup(pc_pool[1], OP_BR);    // same row with another tag
        close_test("install and hit");

        repeat (4) train_branch(1'b0, pc_pool[0], 32'h2000);
        lookup(pc_pool[0], OP_BR);
        repeat (3) train_branch(1'b1, pc_pool[0], 32'h2000);
        train_branch(1'b0, pc_pool[0], 32'h2000);
        idle_cycles(1);
        lookup(pc_pool[0], OP_BR);
        repeat (2) train_branch(1'b1, pc_pool[0], 32'h2000);
        lookup(pc_pool[0], OP_BR);
        repeat (3) train_branch(1'b0, pc_pool[0], 32'h2000);
        lookup(pc_pool[0], OP_BR);
        close_test("counter saturation");

        repeat (2) train_branch(1'b1, pc_pool[0], 32'h2000);
        idle_cycles(2);
        lookup(pc_pool[0], 7'h33);
        lookup(pc_pool[0], 7'h13);
        dis_br_pred = 1'b1;
        lookup(pc_pool[0], OP_BR);
        lookup(pc_pool[0], 7'h6f);
        dis_br_pred = 1'b0;
        lookup(pc_pool[0], OP_BR);
        dis_br_pred = 1'b1;    // disable seen in the cycle after the fetch
        idle_cycles(1);
        dis_br_pred = 1'b0;
        close_test("filters");

        for (int i = 0; i < 6; i++) begin
            drive_cycle(1'b1, pc_pool[0], OP_BR, 1'b1, 1'b1, pc_pool[defer_idx[i]],
                        pc_pool[defer_idx[i]] ^ 32'h8000);
        end
        repeat (3) lookup(pc_pool[0], OP_BR);
        idle_cycles(1);
        lookup(pc_pool[3], OP_BR);
        lookup(pc_pool[5], OP_BR);
        idle_cycles(1);
        lookup(pc_pool[5], OP_BR);
        idle_cycles(4);
        for (int i = 0; i < 6; i++) lookup(pc_pool[defer_idx[i]], OP_BR);
        close_test("write deferral and drop");

        for (int i = 0; i < LEN_RAND; i++) begin
            r = $random(seed);
            dis_br_pred = (r[11:8] == 4'h0);
            drive_cycle(r[1:0] != 2'b00, pc_pool[r[14:12]], op_list[int'(r[20:18]) % 6],
                        r[4:2] < 3'd3, r[5] | r[6], pc_pool[r[17:15]],
                        pc_pool[r[23:21]] + 32'h100);
        end
        dis_br_pred = 1'b0;
        close_test("random mix");

        $display("tests %0d, failing tests %0d, checks %0d, mismatches %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(BUDGET * 100);
        $display("timeout: the run did not finish within %0d cycles", BUDGET);
        $display("Something failed");
        $finish;
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# compile and run the BPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --timescale 1ns/100ps \
    -f tb.f --top-module tb_bpu -Mdir "$BUILD_DIR" -o sim_bpu
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

"./$BUILD_DIR/sim_bpu" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Everything OK" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* src/bpu_lookup.sv */
`timescale 1ns/100ps
`include "bpu_params.svh"

module bpu_lookup
    import bpu_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  t_fetch_req fetch,
    input  logic       dis_br_pred,
    input  logic       cntr_hi,
    input  t_btb_row   rd_row,
    output t_btb_req   lookup_req,
    output t_pred      pred
);

    localparam int IDX_W = $bits(t_btb_idx);

    logic   valid_q;
    t_paddr pc_q;
    logic   is_br_q;
    logic   btb_hit;

    // --------------------------------------------------
    // read request in cycle N
    // --------------------------------------------------
    always_comb begin
        lookup_req       = '0;
        lookup_req.valid = fetch.valid;
        lookup_req.wr    = 1'b0;
        lookup_req.idx   = fetch.pc[`BPU_BTB_IDX_LSB +: IDX_W];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= fetch.valid;
        end
    end

    // payload lines up with the table output
    always_ff @(posedge clk) begin
        pc_q    <= fetch.pc;
        is_br_q <= opcode_is_branch(fetch.instr[6:0]);
    end

    // --------------------------------------------------
    // prediction in cycle N+1
    // --------------------------------------------------
    assign btb_hit = rd_row.valid & (rd_row.pc == pc_q);

    always_comb begin
        pred.valid  = valid_q;
        pred.taken  = valid_q & btb_hit & is_br_q & cntr_hi & ~dis_br_pred;
        pred.pc_nxt = rd_row.target;    // target even when not taken
    end

endmodule

/* src/bpu_params.svh */
`ifndef BPU_PARAMS_SVH
`define BPU_PARAMS_SVH

// physical address width
`define BPU_PADDR_W 32

// --------------------------------------------------
// branch target buffer geometry
// --------------------------------------------------
`define BPU_BTB_ROWS 32
`define BPU_BTB_IDX_LSB 2

// pending installs held by the trainer
`define BPU_TQ_DEPTH 4

`endif

/* src/bpu_pkg.sv */
`include "bpu_params.svh"

package bpu_pkg;

    typedef logic [`BPU_PADDR_W-1:0] t_paddr;
    typedef logic [$clog2(`BPU_BTB_ROWS)-1:0] t_btb_idx;

    // --------------------------------------------------
    // table contents and requests
    // --------------------------------------------------
    typedef struct packed {
        logic   valid;
        t_paddr pc;      // full pc as tag
        t_paddr target;
    } t_btb_row;

    typedef struct packed {
        logic     valid;
        logic     wr;
        t_btb_idx idx;
        t_btb_row row;   // only used on writes
    } t_btb_req;

    // --------------------------------------------------
    // pipeline facing packets
    // --------------------------------------------------
    typedef struct packed {
        logic   valid;
        logic   taken;
        t_paddr pc;
        t_paddr target;
    } t_train_pkt;

    typedef struct packed {
        logic        valid;
        t_paddr      pc;
        logic [31:0] instr;
    } t_fetch_req;

    typedef struct packed {
        logic   valid;
        logic   taken;
        t_paddr pc_nxt;
    } t_pred;

    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    function automatic logic opcode_is_branch(input logic [6:0] opcode);
        return (opcode == OP_BRANCH) | (opcode == OP_JAL) | (opcode == OP_JALR);
    endfunction

endpackage

/* src/bpu_top.sv */
`timescale 1ns/100ps

module bpu_top
    import bpu_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  t_fetch_req fetch,
    input  t_train_pkt train,
    input  logic       dis_br_pred,
    output t_pred      pred,
    output logic       train_drop
);

    t_btb_req lookup_req;
    t_btb_req write_req;
    t_btb_req table_req;
    t_btb_row rd_row;
    logic     write_done;
    logic     cntr_hi;

    // --------------------------------------------------
    // fetch side
    // --------------------------------------------------
    bpu_lookup u_lookup (
        .clk         (clk),
        .reset       (reset),
        .fetch       (fetch),
        .dis_br_pred (dis_br_pred),
        .cntr_hi     (cntr_hi),
        .rd_row      (rd_row),
        .lookup_req  (lookup_req),
        .pred        (pred)
    );

    // execute side
    bpu_trainer u_trainer (
        .clk        (clk),
        .reset      (reset),
        .train      (train),
        .write_done (write_done),
        .write_req  (write_req),
        .cntr_hi    (cntr_hi),
        .train_drop (train_drop)
    );

    // --------------------------------------------------
    // shared table port
    // --------------------------------------------------
    btb_arbiter u_arbiter (
        .lookup_req (lookup_req),
        .write_req  (write_req),
        .table_req  (table_req),
        .write_done (write_done)
    );

    btb_table u_table (
        .clk    (clk),
        .reset  (reset),
        .req    (table_req),
        .rd_row (rd_row)
    );

endmodule

/* src/bpu_trainer.sv */
`timescale 1ns/100ps
`include "bpu_params.svh"

module bpu_trainer
    import bpu_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  t_train_pkt train,
    input  logic       write_done,
    output t_btb_req   write_req,
    output logic       cntr_hi,
    output logic       train_drop
);

    localparam int DEPTH = `BPU_TQ_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int IDX_W = $bits(t_btb_idx);

    logic [1:0]       cntr;
    t_btb_row         queue [DEPTH];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             install;
    logic             push;
    logic             pop;

    // --------------------------------------------------
    // global 2-bit counter
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            cntr <= 2'b01;    // weakly not-taken
        end else if (train.valid) begin
            if (train.taken & (cntr != 2'b11)) begin
                cntr <= cntr + 2'd1;
            end else if (~train.taken & (cntr != 2'b00)) begin
                cntr <= cntr - 2'd1;
            end
        end
    end

    assign cntr_hi = cntr[1];

    // --------------------------------------------------
    // install queue
    // --------------------------------------------------
    assign full    = (count == CNT_W'(DEPTH));
    assign install = train.valid & train.taken;
    assign push    = install & ~full;
    assign pop     = write_done;

    always_ff @(posedge clk) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= (tail == PTR_W'(DEPTH - 1)) ? '0 : tail + 1'b1;
            end
            if (pop) begin
                head <= (head == PTR_W'(DEPTH - 1)) ? '0 : head + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            queue[tail] <= '{valid: 1'b1, pc: train.pc, target: train.target};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            train_drop <= 1'b0;
        end else begin
            train_drop <= install & full;    // install lost
        end
    end

    // head of queue offered to the arbiter
    always_comb begin
        write_req.valid = (count != '0);
        write_req.wr    = 1'b1;
        write_req.idx   = queue[head].pc[`BPU_BTB_IDX_LSB +: IDX_W];
        write_req.row   = queue[head];
    end

endmodule

/* src/btb_arbiter.sv */
`timescale 1ns/100ps

module btb_arbiter
    import bpu_pkg::*;
(
    input  t_btb_req lookup_req,
    input  t_btb_req write_req,
    output t_btb_req table_req,
    output logic     write_done
);

    logic write_grant;

    // --------------------------------------------------
    // fixed priority with lookup first
    // --------------------------------------------------

    // a queued install only gets the port on a cycle without fetch
    assign write_grant = ~lookup_req.valid & write_req.valid;

    always_comb begin
        if (lookup_req.valid) begin
            table_req = lookup_req;
        end else begin
            table_req = write_req;
        end
    end

    assign write_done = write_grant;    // trainer pops on this

endmodule

/* src/btb_table.sv */
`timescale 1ns/100ps
`include "bpu_params.svh"

module btb_table
    import bpu_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  t_btb_req req,
    output t_btb_row rd_row
);

    t_btb_row rows [`BPU_BTB_ROWS];

    // --------------------------------------------------
    // storage with reset clear
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `BPU_BTB_ROWS; i++) begin
                rows[i] <= '0;
            end
        end else if (req.valid & req.wr) begin
            rows[req.idx] <= req.row;
        end
    end

    // registered read port
    always_ff @(posedge clk) begin
        if (req.valid & ~req.wr) begin
            rd_row <= rows[req.idx];    // holds until the next read
        end
    end

endmodule

/* tb.f */
+incdir+src
src/bpu_pkg.sv
src/btb_table.sv
src/btb_arbiter.sv
src/bpu_lookup.sv
src/bpu_trainer.sv
src/bpu_top.sv
bench/bpu_checker.sv
bench/tb_bpu.sv
